//--- design/DaqPkg.sv
`default_nettype none

// Shared types and default ASIC timing for the acquisition controller
package DaqPkg;

    ////////////////////
    // Word widths
    ////////////////////

    localparam int DaqTimeWidth   = 16;  // Programmable times, in Clk cycles
    localparam int StatCountWidth = 16;  // Host statistics counters

    // Time loaded from the host, counted in clock cycles
    typedef logic [DaqTimeWidth-1:0] daqTimeT;

    // Statistics counter, wraps silently at full scale
    typedef logic [StatCountWidth-1:0] statCountT;

    ////////////////////
    // ASIC timing defaults
    ////////////////////

    // Reset hold after power-up, lets the LVDS receivers wake up
    localparam int DefPowerResetCycles = 8;

    // Reset release to first trigger, covers the internal
    // slow and fast clock management of the ASIC
    localparam int DefResetStartCycles = 40;

    // Readout start pulse length
    localparam int DefSroCycles = 16;

endpackage

`default_nettype wire

//--- design/DaqEventIf.sv
`timescale 1ns/1ps
`default_nettype none

// One-cycle events in the Clk domain, built from the ASIC and trigger pins
interface DaqEventIf;

    logic ChipFull;     // ChipSatB fell, ASIC memory full
    logic ReadAllowed;  // ChipSatB rose, readout may start
    logic EndRead;      // EndReadout fell, readout finished
    logic AcqTrigger;   // AcqStart rose, external trigger

    // Synchronizer side
    modport source(output ChipFull, output ReadAllowed, output EndRead, output AcqTrigger);

    // Sequencer side
    modport sink(input ChipFull, input ReadAllowed, input EndRead, input AcqTrigger);

    // Statistics only watch for full memory
    modport monitor(input ChipFull);

endinterface

`default_nettype wire

//--- design/DaqInputSync.sv
`timescale 1ns/1ps
`default_nettype none

// Two-flop synchronizers on the ASIC status and trigger pins,
// followed by registered edge detectors
module DaqInputSync (
    input  logic       Clk,
    input  logic       reset_n,
    input  logic       ChipSatB,     // Low when memory full
    input  logic       EndReadout,   // Active high during readout
    input  logic       AcqStart,     // External trigger
    DaqEventIf.source  Events
);

    localparam int SatBit  = 0;
    localparam int EndBit  = 1;
    localparam int TrigBit = 2;

    // ChipSatB idles high, so its stages come out of reset at 1
    localparam logic [2:0] SyncResetVal = 3'b001;

    logic [2:0] syncQ1;    // First stage may go metastable
    logic [2:0] syncQ2;    // Second stage
    logic       chipFullQ;
    logic       readAllowedQ;
    logic       endReadQ;
    logic       acqTriggerQ;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            syncQ1 <= SyncResetVal;
            syncQ2 <= SyncResetVal;
        end else begin
            syncQ1 <= {AcqStart, EndReadout, ChipSatB};
            syncQ2 <= syncQ1;
        end
    end

    // Edge found between the stages, then registered once more
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            chipFullQ    <= 1'b0;
            readAllowedQ <= 1'b0;
            endReadQ     <= 1'b0;
            acqTriggerQ  <= 1'b0;
        end else begin
            chipFullQ    <= ~syncQ1[SatBit] & syncQ2[SatBit];    // Falling
            readAllowedQ <= syncQ1[SatBit] & ~syncQ2[SatBit];    // Rising
            endReadQ     <= ~syncQ1[EndBit] & syncQ2[EndBit];    // Falling
            acqTriggerQ  <= syncQ1[TrigBit] & ~syncQ2[TrigBit];  // Rising
        end
    end

    assign Events.ChipFull    = chipFullQ;
    assign Events.ReadAllowed = readAllowedQ;
    assign Events.EndRead     = endReadQ;
    assign Events.AcqTrigger  = acqTriggerQ;

endmodule

`default_nettype wire

//--- design/AcqSequencer.sv
`timescale 1ns/1ps
`default_nettype none

// Acquisition sequencer for one power-pulsed readout ASIC
module AcqSequencer import DaqPkg::*; #(
    parameter int PowerResetCycles = 8,   // Reset hold after power-up
    parameter int ResetStartCycles = 40,  // Reset release to arming
    parameter int SroCycles        = 16   // Readout start pulse length
) (
    input  logic      Clk,
    input  logic      reset_n,
    input  logic      ModuleStart,      // Run enable from host
    input  daqTimeT   AcquisitionTime,  // Window length
    input  daqTimeT   EndHoldTime,      // Done strobe length
    DaqEventIf.sink   Events,
    output logic      ResetB,           // ASIC digital reset, active low
    output logic      StartAcq,         // Acquisition window
    output logic      StartReadout,     // Readout start pulse
    output logic      OnceEnd,          // Done strobe
    output logic      PowerOnAnalog,
    output logic      PowerOnDigital,
    output logic      PowerOnDac,
    output logic      AcqClosedByFull,  // Window closed on full memory
    output logic      OnceDone          // Done strobe starts
);

    typedef enum logic [3:0] {
        StIdle,
        StChipReset,
        StPowerOn,
        StRelease,
        StWaitTrigger,  // Armed
        StAcquire,
        StWaitRead,
        StReadoutStart,
        StWaitReadDone,
        StOnceEnd,
        StAllDone
    } seqStateT;

    seqStateT state;
    daqTimeT  delayCount;     // Shared by every timed state
    logic     analogOnState;
    logic     digitalOnState;

    ////////////////////
    // Sequence FSM
    ////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= StIdle;
            delayCount      <= '0;
            ResetB          <= 1'b1;
            StartAcq        <= 1'b0;
            StartReadout    <= 1'b0;
            OnceEnd         <= 1'b0;
            AcqClosedByFull <= 1'b0;
            OnceDone        <= 1'b0;
        end else begin
            AcqClosedByFull <= 1'b0;  // Pulses last one cycle
            OnceDone        <= 1'b0;
            case (state)
                StIdle: begin
                    if (ModuleStart) begin
                        ResetB <= 1'b0;        // Hold reset through power-up
                        state  <= StChipReset;
                    end
                end
                StChipReset: state <= StPowerOn;
                StPowerOn: begin
                    if (delayCount < daqTimeT'(PowerResetCycles)) begin
                        delayCount <= delayCount + 1'b1;
                    end else begin
                        delayCount <= '0;
                        ResetB     <= 1'b1;
                        state      <= StRelease;
                    end
                end
                StRelease: begin
                    if (delayCount < daqTimeT'(ResetStartCycles)) begin
                        delayCount <= delayCount + 1'b1;
                    end else begin
                        delayCount <= '0;
                        state      <= StWaitTrigger;
                    end
                end
                StWaitTrigger: begin
                    if (!ModuleStart) begin
                        state <= StAllDone;        // Shutdown wins over a trigger
                    end else if (Events.AcqTrigger) begin
                        StartAcq <= 1'b1;
                        state    <= StAcquire;
                    end
                end
                StAcquire: begin
                    // Full memory closes the window early
                    if (Events.ChipFull || delayCount >= AcquisitionTime) begin
                        StartAcq        <= 1'b0;
                        AcqClosedByFull <= Events.ChipFull;
                        delayCount      <= '0;
                        state           <= StWaitRead;
                    end else begin
                        delayCount <= delayCount + 1'b1;
                    end
                end
                StWaitRead: begin
                    if (Events.ReadAllowed) begin
                        StartReadout <= 1'b1;
                        state        <= StReadoutStart;
                    end
                end
                StReadoutStart: begin
                    if (delayCount < daqTimeT'(SroCycles)) begin
                        delayCount <= delayCount + 1'b1;
                    end else begin
                        delayCount   <= '0;
                        StartReadout <= 1'b0;
                        state        <= StWaitReadDone;
                    end
                end
                StWaitReadDone: begin
                    if (Events.EndRead) begin
                        OnceEnd  <= 1'b1;
                        OnceDone <= 1'b1;
                        state    <= StOnceEnd;
                    end
                end
                StOnceEnd: begin
                    if (delayCount < EndHoldTime) begin
                        delayCount <= delayCount + 1'b1;
                    end else begin
                        delayCount <= '0;
                        OnceEnd    <= 1'b0;
                        state      <= StWaitTrigger;  // Rearm
                    end
                end
                StAllDone: state <= StIdle;
                default:   state <= StIdle;
            endcase
        end
    end

    ////////////////////
    // Power pulsing
    ////////////////////

    // Analog and DAC on from chip reset, digital a cycle later
    assign analogOnState  = (state != StIdle) && (state != StAllDone);
    assign digitalOnState = analogOnState && (state != StChipReset);

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            PowerOnAnalog  <= 1'b0;
            PowerOnDigital <= 1'b0;
            PowerOnDac     <= 1'b0;
        end else begin
            PowerOnAnalog  <= analogOnState;   // Registered, so one cycle behind state
            PowerOnDac     <= analogOnState;
            PowerOnDigital <= digitalOnState;
        end
    end

    acqReadoutExclusive: assert property (@(posedge Clk) disable iff (!reset_n)
        !(StartAcq && StartReadout));

    noAcqInReset: assert property (@(posedge Clk) disable iff (!reset_n)
        StartAcq |-> ResetB);

    doneWhilePowered: assert property (@(posedge Clk) disable iff (!reset_n)
        OnceEnd |-> PowerOnDigital);

endmodule

`default_nettype wire

//--- design/AcqStats.sv
`timescale 1ns/1ps
`default_nettype none

// Run statistics for the host, cleared at every run start
module AcqStats import DaqPkg::*; (
    input  logic        Clk,
    input  logic        reset_n,
    input  logic        ModuleStart,
    DaqEventIf.monitor  Events,
    input  logic        AcqClosedByFull,  // From sequencer
    input  logic        OnceDone,         // From sequencer
    output statCountT   AcqCount,         // Completed acquisitions
    output statCountT   FullCount         // Windows closed by full memory
);

    logic moduleStartQ;  // Previous ModuleStart, for the run start edge
    logic runStart;

    assign runStart = ModuleStart & ~moduleStartQ;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            moduleStartQ <= 1'b0;
        end else begin
            moduleStartQ <= ModuleStart;
        end
    end

    ////////////////////
    // Counters
    ////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            AcqCount  <= '0;
            FullCount <= '0;
        end else if (runStart) begin
            AcqCount  <= '0;  // New run starts from zero
            FullCount <= '0;
        end else begin
            if (OnceDone) AcqCount <= AcqCount + 1'b1;           // Wraps
            if (AcqClosedByFull) FullCount <= FullCount + 1'b1;
        end
    end

    // Sequencer reacts to ChipFull on the next edge only
    fullFollowsEvent: assert property (@(posedge Clk) disable iff (!reset_n)
        AcqClosedByFull |-> $past(Events.ChipFull));

endmodule

`default_nettype wire

//--- design/DaqTop.sv
`timescale 1ns/1ps
`default_nettype none

// Slave acquisition controller, one readout ASIC
module DaqTop import DaqPkg::*; #(
    parameter int PowerResetCycles = DefPowerResetCycles,
    parameter int ResetStartCycles = DefResetStartCycles,
    parameter int SroCycles        = DefSroCycles
) (
    input  logic      Clk,
    input  logic      reset_n,
    input  logic      ModuleStart,      // Host run enable
    input  logic      AcqStart,         // External trigger, asynchronous
    input  logic      EndReadout,       // From ASIC, asynchronous
    input  logic      ChipSatB,         // From ASIC, asynchronous
    input  daqTimeT   AcquisitionTime,
    input  daqTimeT   EndHoldTime,
    output logic      ResetB,
    output logic      StartAcq,
    output logic      StartReadout,
    output logic      OnceEnd,
    output logic      PowerOnAnalog,
    output logic      PowerOnDigital,
    output logic      PowerOnDac,
    output statCountT AcqCount,
    output statCountT FullCount
);

    DaqEventIf DaqEventIf_inst();  // Synchronized events

    logic acqClosedByFull;
    logic onceDone;

    DaqInputSync DaqInputSync_inst (
        .Clk        (Clk),
        .reset_n    (reset_n),
        .ChipSatB   (ChipSatB),
        .EndReadout (EndReadout),
        .AcqStart   (AcqStart),
        .Events     (DaqEventIf_inst.source)
    );

    AcqSequencer #(
        .PowerResetCycles (PowerResetCycles),
        .ResetStartCycles (ResetStartCycles),
        .SroCycles        (SroCycles)
    ) AcqSequencer_inst (
        .Clk             (Clk),
        .reset_n         (reset_n),
        .ModuleStart     (ModuleStart),
        .AcquisitionTime (AcquisitionTime),
        .EndHoldTime     (EndHoldTime),
        .Events          (DaqEventIf_inst.sink),
        .ResetB          (ResetB),
        .StartAcq        (StartAcq),
        .StartReadout    (StartReadout),
        .OnceEnd         (OnceEnd),
        .PowerOnAnalog   (PowerOnAnalog),
        .PowerOnDigital  (PowerOnDigital),
        .PowerOnDac      (PowerOnDac),
        .AcqClosedByFull (acqClosedByFull),
        .OnceDone        (onceDone)
    );

    AcqStats AcqStats_inst (
        .Clk             (Clk),
        .reset_n         (reset_n),
        .ModuleStart     (ModuleStart),
        .Events          (DaqEventIf_inst.monitor),
        .AcqClosedByFull (acqClosedByFull),
        .OnceDone        (onceDone),
        .AcqCount        (AcqCount),
        .FullCount       (FullCount)
    );

endmodule

`default_nettype wire

//--- include/DaqTbCases.svh
`ifndef DAQ_TB_CASES_SVH
`define DAQ_TB_CASES_SVH

// One acquisition per row, expected widths in Clk cycles
typedef struct packed {
    daqTimeT   acqTime;       // AcquisitionTime
    daqTimeT   endHold;       // EndHoldTime
    logic      chipFull;      // ChipSatB falls inside the window
    daqTimeT   fullOffset;    // Edges from StartAcq rise to ChipSatB fall
    daqTimeT   expAcqWidth;   // StartAcq high
    daqTimeT   expSroWidth;   // StartReadout high
    daqTimeT   expEndWidth;   // OnceEnd high
    statCountT expAcqCount;   // Totals once the row is done
    statCountT expFullCount;
} caseRowT;

localparam int NumCases = 7;

caseRowT caseTable [NumCases];

task automatic fillCaseTable();
    //             acq     end     full  off     acqW    sroW    endW    acqN    fullN
    caseTable[0] = {16'd20, 16'd4,  1'b0, 16'd0, 16'd21, 16'd17, 16'd5,  16'd1, 16'd0};
    caseTable[1] = {16'd0,  16'd0,  1'b0, 16'd0, 16'd1,  16'd17, 16'd1,  16'd2, 16'd0};
    caseTable[2] = {16'd40, 16'd10, 1'b1, 16'd5, 16'd8,  16'd17, 16'd11, 16'd3, 16'd1};
    caseTable[3] = {16'd12, 16'd2,  1'b0, 16'd0, 16'd13, 16'd17, 16'd3,  16'd4, 16'd1};
    caseTable[4] = {16'd30, 16'd7,  1'b1, 16'd1, 16'd4,  16'd17, 16'd8,  16'd5, 16'd2};
    caseTable[5] = {16'd9,  16'd1,  1'b1, 16'd6, 16'd9,  16'd17, 16'd2,  16'd6, 16'd3};
    caseTable[6] = {16'd5,  16'd3,  1'b0, 16'd0, 16'd6,  16'd17, 16'd4,  16'd7, 16'd3};
endtask

`endif

//--- testbench/DaqTopTb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for DaqTop with a behavioral model of the readout ASIC
module DaqTopTb import DaqPkg::*; ();

    localparam int ClkPeriod        = 10;
    localparam int PowerResetCycles = DefPowerResetCycles;
    localparam int ResetStartCycles = DefResetStartCycles;
    localparam int SroCycles        = DefSroCycles;
    localparam int RowOverhead      = 64;  // Model gaps and sync latency per row

    localparam int SelResetB       = 0;  // Output picked by probe()
    localparam int SelStartAcq     = 1;
    localparam int SelStartReadout = 2;
    localparam int SelOnceEnd      = 3;

    logic      Clk;
    logic      reset_n;
    logic      ModuleStart;
    logic      AcqStart;
    logic      EndReadout;
    logic      ChipSatB;
    daqTimeT   AcquisitionTime;
    daqTimeT   EndHoldTime;
    logic      ResetB;
    logic      StartAcq;
    logic      StartReadout;
    logic      OnceEnd;
    logic      PowerOnAnalog;
    logic      PowerOnDigital;
    logic      PowerOnDac;
    statCountT AcqCount;
    statCountT FullCount;

    integer seed;        // $random state
    int     errorTotal;
    int     checkTotal;
    logic   tableReady;  // Watchdog sizes itself from the table

    `include "DaqTbCases.svh"

    DaqTop #(
        .PowerResetCycles (PowerResetCycles),
        .ResetStartCycles (ResetStartCycles),
        .SroCycles        (SroCycles)
    ) DaqTop_inst (
        .Clk             (Clk),
        .reset_n         (reset_n),
        .ModuleStart     (ModuleStart),
        .AcqStart        (AcqStart),
        .EndReadout      (EndReadout),
        .ChipSatB        (ChipSatB),
        .AcquisitionTime (AcquisitionTime),
        .EndHoldTime     (EndHoldTime),
        .ResetB          (ResetB),
        .StartAcq        (StartAcq),
        .StartReadout    (StartReadout),
        .OnceEnd         (OnceEnd),
        .PowerOnAnalog   (PowerOnAnalog),
        .PowerOnDigital  (PowerOnDigital),
        .PowerOnDac      (PowerOnDac),
        .AcqCount        (AcqCount),
        .FullCount       (FullCount)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic stopWithFailure();
        $display("Regression failed");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic checkTime(input string name, input daqTimeT got, input daqTimeT exp);
        checkTotal++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errorTotal++;
            stopWithFailure();
        end
    endtask

    task automatic checkCount(input string name, input statCountT got, input statCountT exp);
        checkTotal++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errorTotal++;
            stopWithFailure();
        end
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        checkTotal++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errorTotal++;
            stopWithFailure();
        end
    endtask

    ////////////////////
    // Timing helpers
    ////////////////////

    function automatic int randomGap(input int minCycles, input int spanCycles);
        return minCycles + ($unsigned($random(seed)) % spanCycles);
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SelResetB:       return ResetB;
            SelStartAcq:     return StartAcq;
            SelStartReadout: return StartReadout;
            default:         return OnceEnd;
        endcase
    endfunction

    task automatic pulsesLow();
        checkLevel("StartAcq", StartAcq, 1'b0);
        checkLevel("StartReadout", StartReadout, 1'b0);
        checkLevel("OnceEnd", OnceEnd, 1'b0);
    endtask

    // Returns just after a rising edge so the caller can drive
    task automatic idleCycles(input int cycles);
        repeat (cycles) begin
            @(negedge Clk);
            pulsesLow();  // Nothing fires without its cause
            @(posedge Clk);
        end
    endtask

    // Rising edges from the last drive until the output reaches level
    task automatic waitForLevel(input int sel, input logic level, output daqTimeT latency);
        latency = '0;
        do begin
            @(posedge Clk);
            latency = latency + 1'b1;
            @(negedge Clk);
        end while (probe(sel) !== level);
    endtask

    // Called at a falling edge where the output already sits at level
    task automatic measureWidth(input int sel, input logic level, output daqTimeT width);
        width = 16'd1;
        @(posedge Clk);
        @(negedge Clk);
        while (probe(sel) === level) begin
            width = width + 1'b1;
            @(posedge Clk);
            @(negedge Clk);
        end
    endtask

    ////////////////////
    // Test phases
    ////////////////////

    task automatic runPowerUp();
        daqTimeT latency;
        daqTimeT width;
        @(negedge Clk);
        checkLevel("ResetB", ResetB, 1'b1);  // Idle values
        pulsesLow();
        checkLevel("PowerOnAnalog", PowerOnAnalog, 1'b0);
        checkLevel("PowerOnDigital", PowerOnDigital, 1'b0);
        checkLevel("PowerOnDac", PowerOnDac, 1'b0);
        @(posedge Clk);
        ModuleStart <= 1'b1;
        waitForLevel(SelResetB, 1'b0, latency);
        checkTime("ResetB fall latency", latency, 16'd1);
        @(posedge Clk);
        @(negedge Clk);
        checkLevel("PowerOnAnalog", PowerOnAnalog, 1'b1);    // One cycle after ResetB falls
        checkLevel("PowerOnDac", PowerOnDac, 1'b1);
        checkLevel("PowerOnDigital", PowerOnDigital, 1'b0);  // Still a cycle behind
        checkCount("AcqCount", AcqCount, '0);                // Run start clears both
        checkCount("FullCount", FullCount, '0);
        @(posedge Clk);
        @(negedge Clk);
        checkLevel("PowerOnDigital", PowerOnDigital, 1'b1);
        measureWidth(SelResetB, 1'b0, width);
        checkTime("ResetB low width", width + 16'd2, PowerResetCycles + 2);
        idleCycles(ResetStartCycles + 1);  // Sequencer armed at the end of the release wait
    endtask

    task automatic runAcquisition(input caseRowT row);
        daqTimeT latency;
        daqTimeT width;
        daqTimeT cyc;
        logic    closed;
        idleCycles(randomGap(2, 6));  // Armed with no trigger yet
        AcquisitionTime <= row.acqTime;
        EndHoldTime     <= row.endHold;
        AcqStart        <= 1'b1;
        waitForLevel(SelStartAcq, 1'b1, latency);
        checkTime("AcqStart to StartAcq latency", latency, 16'd3);
        width  = 16'd1;
        cyc    = '0;
        closed = 1'b0;
        while (!closed) begin
            @(posedge Clk);
            cyc = cyc + 1'b1;
            if (cyc == 16'd1) AcqStart <= 1'b0;
            if (row.chipFull && cyc == row.fullOffset) ChipSatB <= 1'b0;  // Memory full
            @(negedge Clk);
            if (StartAcq) width = width + 1'b1;
            else closed = 1'b1;
        end
        if (row.chipFull) begin
            checkTime("StartAcq width after ChipSatB fall", width, row.fullOffset + 16'd3);
            checkLevel("StartAcq within AcquisitionTime", width <= row.acqTime + 16'd1, 1'b1);
        end else begin
            checkTime("StartAcq width", width, row.acqTime + 16'd1);
        end
        checkTime("StartAcq table width", width, row.expAcqWidth);

        // ASIC model pulses the full flag before readout is allowed
        if (!row.chipFull) begin
            idleCycles(randomGap(1, 4));
            ChipSatB <= 1'b0;
        end
        idleCycles(randomGap(2, 4));
        ChipSatB <= 1'b1;
        waitForLevel(SelStartReadout, 1'b1, latency);
        checkTime("ChipSatB to StartReadout latency", latency, 16'd3);
        measureWidth(SelStartReadout, 1'b1, width);
        checkTime("StartReadout width", width, row.expSroWidth);

        idleCycles(randomGap(1, 4));
        EndReadout <= 1'b1;  // Readout busy
        idleCycles(randomGap(2, 4));
        EndReadout <= 1'b0;
        waitForLevel(SelOnceEnd, 1'b1, latency);
        checkTime("EndReadout to OnceEnd latency", latency, 16'd3);
        measureWidth(SelOnceEnd, 1'b1, width);
        checkTime("OnceEnd width", width, row.expEndWidth);
        checkCount("AcqCount", AcqCount, row.expAcqCount);
        checkCount("FullCount", FullCount, row.expFullCount);
    endtask

    task automatic shutdownRun();
        idleCycles(randomGap(2, 4));
        ModuleStart <= 1'b0;
        @(posedge Clk);
        @(posedge Clk);
        @(negedge Clk);
        checkLevel("PowerOnAnalog", PowerOnAnalog, 1'b0);  // Off within two cycles
        checkLevel("PowerOnDigital", PowerOnDigital, 1'b0);
        checkLevel("PowerOnDac", PowerOnDac, 1'b0);
        checkLevel("ResetB", ResetB, 1'b1);
        @(posedge Clk);
        AcqStart <= 1'b1;  // Trigger while stopped is dropped
        idleCycles(8);
        AcqStart <= 1'b0;
        idleCycles(4);
        @(negedge Clk);
        checkCount("AcqCount", AcqCount, NumCases);  // Held until restart
    endtask

    initial begin : watchdog
        int rowCycles;
        int maxRow;
        int limitCycles;
        wait (tableReady === 1'b1);
        maxRow = 0;
        foreach (caseTable[i]) begin
            rowCycles = caseTable[i].acqTime + caseTable[i].endHold + SroCycles + RowOverhead;
            if (rowCycles > maxRow) maxRow = rowCycles;
        end
        // Table, restart row, shutdown and two power-ups
        limitCycles = (NumCases + 2) * maxRow
                    + 2 * (PowerResetCycles + ResetStartCycles + 16) + RowOverhead;
        repeat (limitCycles) @(posedge Clk);
        $display("Timeout: the acquisition sequence did not finish within %0d cycles",
                 limitCycles);
        stopWithFailure();
    end

    initial begin
        seed            = 32'h48826326;
        errorTotal      = 0;
        checkTotal      = 0;
        reset_n         = 1'b0;
        ModuleStart     = 1'b0;
        AcqStart        = 1'b0;
        EndReadout      = 1'b0;
        ChipSatB        = 1'b1;  // Memory not full
        AcquisitionTime = '0;
        EndHoldTime     = '0;
        fillCaseTable();
        tableReady = 1'b1;
        repeat (2) @(posedge Clk);
        reset_n <= 1'b1;
        @(negedge Clk);
        checkCount("AcqCount", AcqCount, '0);
        checkCount("FullCount", FullCount, '0);

        runPowerUp();
        for (int i = 0; i < NumCases; i++) begin
            runAcquisition(caseTable[i]);
        end
        shutdownRun();
        runPowerUp();                  // Restart from cleared counters
        runAcquisition(caseTable[0]);

        $display("%0d checks over %0d acquisitions", checkTotal, NumCases + 1);
        if (errorTotal == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stopWithFailure();
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
design/DaqPkg.sv
design/DaqEventIf.sv
design/DaqInputSync.sv
design/AcqSequencer.sv
design/AcqStats.sv
design/DaqTop.sv
testbench/DaqTopTb.sv
